/* cdc_fifo.sv */
// Clock domain crossing FIFO top

`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_defs.svh"

module cdc_fifo (
  input  logic                elem_in_clk_i,     // Input clock
  input  logic                elem_out_clk_i,    // Output clock
  input  logic                reset_i,           // Sync reset, both domains

  input  cdc_fifo_pkg::elem_t elem_in_i,         // Input element
  input  logic                elem_in_valid_i,   // Input valid
  output logic                elem_in_ready_o,   // Input ready

  output cdc_fifo_pkg::elem_t elem_out_o,        // Output element
  output logic                elem_out_valid_o,  // Output valid
  input  logic                elem_out_ready_i   // Output ready
);

  //////////////////////////////////////////////////////////////////////
  // Wires
  //////////////////////////////////////////////////////////////////////

  logic               wr_inc;       // Input transfer
  logic               rd_inc;       // Output transfer

  cdc_fifo_pkg::ptr_t wr_bin;       // Write count, input domain
  cdc_fifo_pkg::ptr_t wr_gray;      // Write Gray, input domain
  cdc_fifo_pkg::ptr_t rd_bin;       // Read count, output domain
  cdc_fifo_pkg::ptr_t rd_gray;      // Read Gray, output domain

  cdc_fifo_pkg::ptr_t wr_gray_sync; // Write Gray in output domain
  cdc_fifo_pkg::ptr_t rd_gray_sync; // Read Gray in input domain

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  cdc_fifo_ctrl u_ctrl (
    .elem_in_clk_i   (elem_in_clk_i),
    .elem_out_clk_i  (elem_out_clk_i),
    .reset_i         (reset_i),
    .elem_in_valid_i (elem_in_valid_i),
    .elem_in_ready_o (elem_in_ready_o),
    .elem_out_valid_o(elem_out_valid_o),
    .elem_out_ready_i(elem_out_ready_i),
    .wr_gray_i       (wr_gray),
    .rd_gray_sync_i  (rd_gray_sync),
    .rd_gray_i       (rd_gray),
    .wr_gray_sync_i  (wr_gray_sync),
    .wr_inc_o        (wr_inc),
    .rd_inc_o        (rd_inc)
  );

  //////////////////////////////////////////////////////////////////////
  // Pointers and crossings
  //////////////////////////////////////////////////////////////////////

  gray_ptr u_wr_ptr (
    .clk_i  (elem_in_clk_i),
    .reset_i(reset_i),
    .inc_i  (wr_inc),
    .bin_o  (wr_bin),
    .gray_o (wr_gray)
  );

  gray_ptr u_rd_ptr (
    .clk_i  (elem_out_clk_i),
    .reset_i(reset_i),
    .inc_i  (rd_inc),
    .bin_o  (rd_bin),
    .gray_o (rd_gray)
  );

  ptr_sync u_rd_sync (  // Read pointer into input domain
    .clk_i  (elem_in_clk_i),
    .reset_i(reset_i),
    .gray_i (rd_gray),
    .gray_o (rd_gray_sync)
  );

  ptr_sync u_wr_sync (  // Write pointer into output domain
    .clk_i  (elem_out_clk_i),
    .reset_i(reset_i),
    .gray_i (wr_gray),
    .gray_o (wr_gray_sync)
  );

  dual_clock_ram u_ram (
    .wr_clk_i(elem_in_clk_i),
    .we_i    (wr_inc),
    .waddr_i (wr_bin[`CDC_FIFO_SIZE-1:0]),  // Drop wrap bit
    .wdata_i (elem_in_i),
    .raddr_i (rd_bin[`CDC_FIFO_SIZE-1:0]),  // Drop wrap bit
    .rdata_o (elem_out_o)
  );

endmodule

`default_nettype wire

/* cdc_fifo_ctrl.sv */
// CDC FIFO full/empty control

`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_defs.svh"

module cdc_fifo_ctrl (
  input  logic               elem_in_clk_i,     // Input clock
  input  logic               elem_out_clk_i,    // Output clock
  input  logic               reset_i,           // Sync reset, active high

  input  logic               elem_in_valid_i,   // Input valid
  output logic               elem_in_ready_o,   // Input ready
  output logic               elem_out_valid_o,  // Output valid
  input  logic               elem_out_ready_i,  // Output ready

  input  cdc_fifo_pkg::ptr_t wr_gray_i,         // Write pointer, input domain
  input  cdc_fifo_pkg::ptr_t rd_gray_sync_i,    // Read pointer seen by input side
  input  cdc_fifo_pkg::ptr_t rd_gray_i,         // Read pointer, output domain
  input  cdc_fifo_pkg::ptr_t wr_gray_sync_i,    // Write pointer seen by output side

  output logic               wr_inc_o,          // Write accepted
  output logic               rd_inc_o           // Read accepted
);

  //////////////////////////////////////////////////////////////////////
  // Full and empty
  //////////////////////////////////////////////////////////////////////

  cdc_fifo_pkg::ptr_t rd_gray_flip;  // Read pointer one lap behind
  logic               full;          // Input side sees no free slot
  logic               empty;         // Output side sees nothing stored

  // A lap in Gray code flips the top two bits
  assign rd_gray_flip = rd_gray_sync_i
                        ^ (cdc_fifo_pkg::ptr_t'(2'b11) << (`CDC_FIFO_SIZE - 1));

  assign full  = (wr_gray_i == rd_gray_flip);    // Pessimistic, read may be ahead
  assign empty = (rd_gray_i == wr_gray_sync_i);  // Pessimistic, write may be ahead

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  assign elem_in_ready_o  = ~full;
  assign elem_out_valid_o = ~empty;

  assign wr_inc_o = elem_in_valid_i & elem_in_ready_o;    // Input transfer
  assign rd_inc_o = elem_out_valid_o & elem_out_ready_i;  // Output transfer

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // No write while full
  a_no_write_full : assert property (@(posedge elem_in_clk_i) disable iff (reset_i)
    full |=> $stable(wr_gray_i))
    else $error("cdc_fifo_ctrl: write pointer moved while full");

  // No read while empty
  a_no_read_empty : assert property (@(posedge elem_out_clk_i) disable iff (reset_i)
    empty |=> $stable(rd_gray_i))
    else $error("cdc_fifo_ctrl: read pointer moved while empty");

  // Stalled output keeps its element offered
  a_valid_held : assert property (@(posedge elem_out_clk_i) disable iff (reset_i)
    elem_out_valid_o && !elem_out_ready_i |=> elem_out_valid_o && $stable(rd_gray_i))
    else $error("cdc_fifo_ctrl: output valid dropped while stalled");

endmodule

`default_nettype wire

/* cdc_fifo_defs.svh */
// CDC FIFO sizing macros

`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// Bits per stream element
`define CDC_FIFO_ELEM_WIDTH 8

// log2 of FIFO depth, legal range 1 to 4
`define CDC_FIFO_SIZE 3

// Number of storage slots
`define CDC_FIFO_DEPTH (1 << `CDC_FIFO_SIZE)

`endif

/* cdc_fifo_pkg.sv */
// CDC FIFO shared types

`default_nettype none

`include "cdc_fifo_defs.svh"

package cdc_fifo_pkg;

  // One element of the stream
  typedef logic [`CDC_FIFO_ELEM_WIDTH-1:0] elem_t;

  // Pointer, top bit is the wrap bit
  typedef logic [`CDC_FIFO_SIZE:0] ptr_t;

  // Memory address, low bits of a pointer
  typedef logic [`CDC_FIFO_SIZE-1:0] addr_t;

endpackage

`default_nettype wire

/* cdc_fifo_tb.sv */
// CDC FIFO testbench

`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_defs.svh"

module cdc_fifo_tb;

  localparam int DEPTH        = `CDC_FIFO_DEPTH;
  localparam int RANDOM_COUNT = 4000;  // Elements in the random stream
  localparam int IN_HALF      = 4;     // 8 ns input clock
  localparam int OUT_HALF     = 6;     // 12 ns output clock
  localparam int WATCHDOG_NS  = RANDOM_COUNT * 6 * 2 * OUT_HALF + 20000;

  //////////////////////////////////////////////////////////////////////
  // DUT and clocks
  //////////////////////////////////////////////////////////////////////

  logic                in_clk = 1'b0;  // Edges at 4 + 8k
  logic                out_clk = 1'b0; // Edges at 6 + 12k never meet an input edge
  logic                reset;
  cdc_fifo_pkg::elem_t in_data;
  logic                in_valid;
  logic                in_ready;
  cdc_fifo_pkg::elem_t out_data;
  logic                out_valid;
  logic                out_ready;

  always #IN_HALF in_clk = ~in_clk;
  always #OUT_HALF out_clk = ~out_clk;

  cdc_fifo uut (
    .elem_in_clk_i   (in_clk),
    .elem_out_clk_i  (out_clk),
    .reset_i         (reset),
    .elem_in_i       (in_data),
    .elem_in_valid_i (in_valid),
    .elem_in_ready_o (in_ready),
    .elem_out_o      (out_data),
    .elem_out_valid_o(out_valid),
    .elem_out_ready_i(out_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  cdc_fifo_pkg::elem_t model_q [$];  // Every accepted element in order
  int     in_count    = 0;           // Input transfers
  int     out_count   = 0;           // Output transfers
  int     main_errors = 0;
  int     cmp_errors  = 0;
  int     mon_errors  = 0;
  integer seed        = 60;
  string  test_name   = "reset";

  // Next element the FIFO owes the output side
  function automatic cdc_fifo_pkg::elem_t expected_elem();
    return model_q[out_count];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // Input monitor sees pre-edge values
  always @(posedge in_clk) begin
    if (!reset) begin
      if (in_ready && (in_count - out_count) >= DEPTH) begin
        report_fault("input ready is high while the FIFO holds a full set of unread elements");
        mon_errors++;
      end
      if (in_valid && in_ready) begin
        model_q.push_back(in_data);
        in_count++;
      end
    end
  end

  // Compare every output transfer with the model
  always @(posedge out_clk) begin
    if (!reset && out_valid && out_ready) begin
      if (out_count >= in_count) begin
        report_fault("output delivered an element that was never written");
        cmp_errors++;
      end else if (out_data !== expected_elem()) begin
        report_mismatch(test_name, expected_elem(), out_data);
        cmp_errors++;
      end
      out_count++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Offer one element and hold it until accepted
  task automatic push_elem(input cdc_fifo_pkg::elem_t data);
    in_data  = data;
    in_valid = 1'b1;
    do begin
      @(posedge in_clk);
    end while (in_ready !== 1'b1);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_random(input int count);
    logic [31:0] rnd;
    for (int i = 0; i < count; i++) begin
      rnd = $random(seed);
      repeat (rnd[1:0]) begin  // Idle gap of 0 to 3 cycles
        @(posedge in_clk);
        #1;
      end
      push_elem(cdc_fifo_pkg::elem_t'(rnd >> 8));
    end
  endtask

  task automatic receive_random(input int target);
    logic [31:0] rnd;
    @(posedge out_clk);
    #1;
    while (out_count < target) begin
      rnd       = $random(seed);
      out_ready = rnd[0];  // Ready about half the time
      @(posedge out_clk);
      #1;
    end
    out_ready = 1'b1;  // Keep reading so a surplus element would leave
    repeat (2 * DEPTH) begin
      @(posedge out_clk);
      #1;
    end
    out_ready = 1'b0;
  endtask

  // Keep valid high for a number of input cycles with new data per transfer
  task automatic hold_input(input int cycles);
    logic [31:0] rnd;
    logic        accepted;
    rnd      = $random(seed);
    in_data  = cdc_fifo_pkg::elem_t'(rnd);
    in_valid = 1'b1;
    repeat (cycles) begin
      @(posedge in_clk);
      accepted = in_ready;
      #1;
      if (accepted) begin
        rnd     = $random(seed);
        in_data = cdc_fifo_pkg::elem_t'(rnd);
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic read_count(input int count);
    int target;
    target = out_count + count;
    @(posedge out_clk);
    #1;
    out_ready = 1'b1;
    while (out_count < target) begin
      @(posedge out_clk);
      #1;
    end
    out_ready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int base_in;
    int base_out;
    int wait_cycles;
    int total;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    reset     = 1'b1;
    repeat (2) @(posedge out_clk);  // Two cycles of the slower clock
    #1 reset = 1'b0;

    @(posedge in_clk);
    #1;
    if (in_ready !== 1'b1) begin
      report_mismatch("reset ready", 1, in_ready);
      main_errors++;
    end
    if (out_valid !== 1'b0) begin
      report_mismatch("reset valid", 0, out_valid);
      main_errors++;
    end

    test_name = "random stream";
    fork
      send_random(RANDOM_COUNT);
      receive_random(RANDOM_COUNT);
    join
    if (out_count != in_count) begin
      report_mismatch("random read", in_count, out_count);
      main_errors++;
    end

    repeat (4) @(posedge in_clk);  // Let the last read reach the input side
    #1;
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
      report_fault("FIFO is not idle after the random stream");
      main_errors++;
    end

    // Fill while the output side is stalled
    test_name = "fill";
    base_in   = in_count;
    hold_input(2 * DEPTH + 8);
    if (in_count - base_in != DEPTH) begin
      report_mismatch("fill count", DEPTH, in_count - base_in);
      main_errors++;
    end
    repeat (6) begin
      @(posedge out_clk);
      #1;
      if (in_ready !== 1'b0) begin
        report_mismatch("fill ready", 0, in_ready);
        main_errors++;
      end
      if (out_valid !== 1'b1) begin
        report_mismatch("stall valid", 1, out_valid);
        main_errors++;
      end
      if (out_data !== expected_elem()) begin
        report_mismatch("stall data", expected_elem(), out_data);
        main_errors++;
      end
    end

    // Two reads free two slots
    test_name = "recovery";
    @(posedge in_clk);
    #1;
    base_in  = in_count;
    base_out = out_count;
    fork
      hold_input(40);
      read_count(2);
    join
    if (out_count - base_out != 2) begin
      report_mismatch("recovery read", 2, out_count - base_out);
      main_errors++;
    end
    if (in_count - base_in != 2) begin
      report_mismatch("recovery written", 2, in_count - base_in);
      main_errors++;
    end

    test_name   = "drain";
    base_out    = out_count;
    wait_cycles = 0;
    @(posedge out_clk);
    #1;
    out_ready = 1'b1;
    while (out_count < in_count && wait_cycles < 8 * DEPTH) begin
      @(posedge out_clk);
      #1;
      wait_cycles++;
    end
    if (out_count - base_out != DEPTH) begin
      report_mismatch("drain count", DEPTH, out_count - base_out);
      main_errors++;
    end
    repeat (10) begin
      @(posedge out_clk);
      #1;
      if (out_valid !== 1'b0) begin
        report_mismatch("drain valid", 0, out_valid);
        main_errors++;
      end
    end
    out_ready = 1'b0;

    total = main_errors + cmp_errors + mon_errors;
    $display("Errors: %0d, elements written: %0d, elements read: %0d",
             total, in_count, out_count);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the random stream length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
    $display("Errors: %0d, elements written: %0d, elements read: %0d",
             main_errors + cmp_errors + mon_errors, in_count, out_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* dual_clock_ram.sv */
// Dual-clock FIFO storage

`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_defs.svh"

module dual_clock_ram (
  input  logic                wr_clk_i,  // Write side clock
  input  logic                we_i,      // Write enable
  input  cdc_fifo_pkg::addr_t waddr_i,   // Write slot
  input  cdc_fifo_pkg::elem_t wdata_i,   // Element to store
  input  cdc_fifo_pkg::addr_t raddr_i,   // Read slot
  output cdc_fifo_pkg::elem_t rdata_o    // Element at read slot
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  cdc_fifo_pkg::elem_t mem_q [`CDC_FIFO_DEPTH];  // One entry per slot

  // Write port, input domain only
  always_ff @(posedge wr_clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Async read at the read pointer. The slot under raddr_i is never
  // the one being written, since empty/full keep the pointers apart
  assign rdata_o = mem_q[raddr_i];

endmodule

`default_nettype wire

/* gray_ptr.sv */
// Binary and Gray pointer counter

`timescale 1ns/1ns
`default_nettype none

module gray_ptr (
  input  logic               clk_i,    // Domain clock
  input  logic               reset_i,  // Active-high synchronous reset
  input  logic               inc_i,    // Advance by one slot
  output cdc_fifo_pkg::ptr_t bin_o,    // Binary count
  output cdc_fifo_pkg::ptr_t gray_o    // Registered Gray count
);

  //////////////////////////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////////////////////////

  cdc_fifo_pkg::ptr_t bin_q;      // Binary count register
  cdc_fifo_pkg::ptr_t gray_q;     // Gray count register
  cdc_fifo_pkg::ptr_t bin_next;   // Count after one step
  cdc_fifo_pkg::ptr_t gray_next;  // Gray form of next count

  assign bin_next  = bin_q + 1'b1;                // Wraps at 2*depth
  assign gray_next = bin_next ^ (bin_next >> 1);  // Binary to Gray

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bin_q  <= '0;
      gray_q <= '0;
    end else if (inc_i) begin
      bin_q  <= bin_next;
      gray_q <= gray_next;  // Flop output without decode glitch
    end
  end

  assign bin_o  = bin_q;
  assign gray_o = gray_q;  // Crosses to the other domain

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Only one bit may toggle per step or the synchronizer can tear
  a_gray_one_bit : assert property (@(posedge clk_i) disable iff (reset_i)
    $countones(gray_q ^ $past(gray_q)) <= 1)
    else $error("gray_ptr: Gray count moved by more than one bit");

endmodule

`default_nettype wire

/* ptr_sync.sv */
// Two-flop Gray pointer synchronizer

`timescale 1ns/1ns
`default_nettype none

`include "cdc_fifo_defs.svh"

module ptr_sync (
  input  logic               clk_i,    // Destination clock
  input  logic               reset_i,  // Sync reset, active high
  input  cdc_fifo_pkg::ptr_t gray_i,   // Gray pointer from source domain
  output cdc_fifo_pkg::ptr_t gray_o    // Gray pointer in destination domain
);

  cdc_fifo_pkg::ptr_t meta_q;  // First stage, may go metastable
  cdc_fifo_pkg::ptr_t sync_q;  // Second stage, settled

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= gray_i;
      sync_q <= meta_q;
    end
  end

  assign gray_o = sync_q;

  // Gray to binary, only for the check below
  function automatic cdc_fifo_pkg::ptr_t gray_to_bin(input cdc_fifo_pkg::ptr_t g);
    cdc_fifo_pkg::ptr_t b;
    b[`CDC_FIFO_SIZE] = g[`CDC_FIFO_SIZE];
    for (int i = `CDC_FIFO_SIZE - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];  // Running XOR from the top
    end
    return b;
  endfunction

  // A slower destination may skip codes, but the pointer only moves
  // forward and never by more than one FIFO depth per sample
  a_sync_forward : assert property (@(posedge clk_i) disable iff (reset_i)
    cdc_fifo_pkg::ptr_t'(gray_to_bin(sync_q) - gray_to_bin($past(sync_q)))
      <= `CDC_FIFO_DEPTH)
    else $error("ptr_sync: synchronized pointer jumped or moved backward");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the CDC FIFO testbench with Verilator.
# Exit status is 0 only when the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

if ! verilator --binary --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module cdc_fifo_tb -f vlog.f -o sim_cdc_fifo; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_cdc_fifo 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TEST RESULT: PASS'; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* vlog.f */
+incdir+.
cdc_fifo_pkg.sv
gray_ptr.sv
ptr_sync.sv
dual_clock_ram.sv
cdc_fifo_ctrl.sv
cdc_fifo.sv
cdc_fifo_tb.sv
